/* design/vtx_pkg.sv */
package vtx_pkg;

	// ============================================================
	// data widths
	// ============================================================
	typedef logic [23:0] pixel_t;      // r in 23:16, g in 15:8, b in 7:0
	typedef logic [7:0] byte_t;
	typedef logic [15:0] seg_num_t;
	typedef logic [31:0] count_t;
	typedef logic [1:0] speed_t;

	// link speed codes
	localparam speed_t SPEED_STOP = 2'd0;
	localparam speed_t SPEED_10 = 2'd1;
	localparam speed_t SPEED_100 = 2'd2;
	localparam speed_t SPEED_1000 = 2'd3;

	// ============================================================
	// register access
	// ============================================================
	typedef logic [3:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	localparam axil_addr_t REG_CTRL = 4'h0;   // enable, speed
	localparam axil_addr_t REG_IDS = 4'h4;    // txid, aux
	localparam axil_addr_t REG_SENT = 4'h8;   // frames sent
	localparam axil_addr_t REG_DROP = 4'hC;   // pixels dropped

	localparam logic [1:0] AXIL_OKAY = 2'b00;
	localparam logic [1:0] AXIL_SLVERR = 2'b10;

	// ============================================================
	// frame format
	// ============================================================
	localparam int HDR_BYTES = 4;   // txid, aux, seg hi, seg lo

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		PIXELS
	} build_state_t;

	// index width, never below one bit
	function automatic int addr_w(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* design/seg_bus_if.sv */
`timescale 1ns/100ps

interface seg_bus_if #(
	parameter int SEG_PIXELS = 16
);
	import vtx_pkg::*;

	localparam int AW = addr_w(SEG_PIXELS);

	// write side
	logic wr_en;
	logic [AW-1:0] wr_addr;
	pixel_t wr_pixel;
	logic commit;         // with last word, sets full

	// buffer state and read data
	logic full;
	pixel_t rd_pixel;     // one cycle after rd_addr

	// read side
	logic [AW-1:0] rd_addr;
	logic seg_release;    // clears full

	modport writer (output wr_en, wr_addr, wr_pixel, commit, input full);
	modport buffer (
		input wr_en, wr_addr, wr_pixel, commit, rd_addr, seg_release,
		output full, rd_pixel
	);
	modport reader (output rd_addr, seg_release, input full, rd_pixel);

endinterface

/* design/segment_buffer.sv */
`timescale 1ns/100ps

module segment_buffer #(
	parameter int SEG_PIXELS = 16
) (
	input logic clk125MHz,
	input logic reset,
	seg_bus_if.buffer seg
);
	import vtx_pkg::*;

	pixel_t mem [SEG_PIXELS];

	// ============================================================
	// storage
	// ============================================================

	// single write port, lands at the clock edge
	always_ff @(posedge clk125MHz) begin
		if (seg.wr_en)
			mem[seg.wr_addr] <= seg.wr_pixel;
	end

	// registered read, free running on rd_addr
	always_ff @(posedge clk125MHz) begin
		seg.rd_pixel <= mem[seg.rd_addr];
	end

	// ============================================================
	// ownership flag
	// ============================================================
	// high means the segment belongs to the frame builder
	always_ff @(posedge clk125MHz) begin
		if (reset)
			seg.full <= 1'b0;
		else if (seg.commit)
			seg.full <= 1'b1;   // last word written
		else if (seg.seg_release)
			seg.full <= 1'b0;   // frame sent
	end

endmodule

/* design/pixel_distributor.sv */
`timescale 1ns/100ps

module pixel_distributor #(
	parameter int SEG_PIXELS = 16,
	parameter int NUM_SEGS = 4
) (
	input logic clk125MHz,
	input logic reset,
	input vtx_pkg::pixel_t pixel,
	input logic pixel_valid,
	seg_bus_if.writer segs [NUM_SEGS],
	output logic pixel_drop
);
	import vtx_pkg::*;

	localparam int AW = addr_w(SEG_PIXELS);
	localparam int SW = addr_w(NUM_SEGS);

	logic [SW-1:0] wr_idx;      // buffer being filled
	logic [AW-1:0] word_idx;    // next word in that buffer
	logic [NUM_SEGS-1:0] full_vec;
	logic target_full;
	logic accept;
	logic last_word;

	// fan out to every buffer, only the selected one sees the strobes
	for (genvar i = 0; i < NUM_SEGS; i++) begin : g_seg
		assign full_vec[i] = segs[i].full;
		assign segs[i].wr_en = accept && (wr_idx == SW'(i));
		assign segs[i].wr_addr = word_idx;
		assign segs[i].wr_pixel = pixel;
		assign segs[i].commit = accept && last_word && (wr_idx == SW'(i));
	end

	assign target_full = full_vec[wr_idx];
	assign accept = pixel_valid && !target_full;
	assign pixel_drop = pixel_valid && target_full;   // same cycle as the pixel
	assign last_word = (word_idx == AW'(SEG_PIXELS - 1));

	// ============================================================
	// write position
	// ============================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			wr_idx <= '0;
			word_idx <= '0;
		end else if (accept) begin
			if (last_word) begin
				word_idx <= '0;
				// next buffer in ring order
				if (wr_idx == SW'(NUM_SEGS - 1))
					wr_idx <= '0;
				else
					wr_idx <= wr_idx + 1'b1;
			end else begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

/* design/frame_builder.sv */
`timescale 1ns/100ps

module frame_builder #(
	parameter int SEG_PIXELS = 16,
	parameter int NUM_SEGS = 4
) (
	input logic clk125MHz,
	input logic reset,
	input logic enable,
	input vtx_pkg::speed_t speed,
	input vtx_pkg::byte_t txid,
	input vtx_pkg::byte_t aux,
	seg_bus_if.reader segs [NUM_SEGS],
	output vtx_pkg::byte_t tx_data,
	output logic tx_valid,
	output logic tx_last,
	output logic frame_done
);
	import vtx_pkg::*;

	localparam int AW = addr_w(SEG_PIXELS);
	localparam int SW = addr_w(NUM_SEGS);

	speed_t speed_q;
	logic [6:0] pace_cnt;
	logic [6:0] pace_top;
	logic pace_last;
	logic advance;

	logic [NUM_SEGS-1:0] full_vec;
	pixel_t rd_vec [NUM_SEGS];
	logic [NUM_SEGS-1:0] rel_vec;
	logic [AW-1:0] rd_addr;

	build_state_t state;
	logic [SW-1:0] rd_idx;      // buffer being sent
	logic [1:0] hdr_cnt;
	logic [1:0] rgb_sel;        // 0 red, 1 green, 2 blue
	logic [AW-1:0] pix_cnt;
	seg_num_t segment_num;
	pixel_t pix_q;
	pixel_t cur_pixel;
	logic frame_end;
	logic seg_ready;

	// ============================================================
	// byte pacing
	// ============================================================
	always_comb begin
		case (speed_q)
			SPEED_10: pace_top = 7'd99;
			SPEED_100: pace_top = 7'd9;
			SPEED_1000: pace_top = 7'd0;
			default: pace_top = 7'd0;
		endcase
	end

	assign pace_last = (pace_cnt == pace_top);
	assign advance = (speed_q != SPEED_STOP) && pace_last;

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			speed_q <= SPEED_STOP;
			pace_cnt <= '0;
		end else begin
			speed_q <= speed;
			if (speed != speed_q || pace_last)   // restart count on a new speed
				pace_cnt <= '0;
			else
				pace_cnt <= pace_cnt + 7'd1;
		end
	end

	// ============================================================
	// segment buffers
	// ============================================================
	for (genvar i = 0; i < NUM_SEGS; i++) begin : g_seg
		assign full_vec[i] = segs[i].full;
		assign rd_vec[i] = segs[i].rd_pixel;
		assign segs[i].rd_addr = rd_addr;
		assign segs[i].seg_release = rel_vec[i];
	end

	assign cur_pixel = rd_vec[rd_idx];
	// a buffer just released still shows full for one cycle
	assign seg_ready = full_vec[rd_idx] && !rel_vec[rd_idx];
	assign frame_end = advance && (state == PIXELS) && (rgb_sel == 2'd2) &&
		(pix_cnt == AW'(SEG_PIXELS - 1));
	assign frame_done = tx_last;

	// ============================================================
	// framing FSM
	// ============================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= IDLE;
			rd_idx <= '0;
			hdr_cnt <= '0;
			rgb_sel <= '0;
			pix_cnt <= '0;
			rd_addr <= '0;
			segment_num <= '0;
			tx_valid <= 1'b0;
			tx_last <= 1'b0;
			rel_vec <= '0;
		end else begin
			tx_valid <= 1'b0;
			tx_last <= frame_end;
			rel_vec <= '0;
			if (frame_end)
				rel_vec[rd_idx] <= 1'b1;
			if (advance) begin
				case (state)
					IDLE: begin
						if (enable && seg_ready) begin
							tx_valid <= 1'b1;   // txid byte
							hdr_cnt <= 2'd1;
							state <= HEADER;
						end
					end
					HEADER: begin
						tx_valid <= 1'b1;
						hdr_cnt <= hdr_cnt + 2'd1;
						if (hdr_cnt == 2'(HDR_BYTES - 1)) begin
							state <= PIXELS;
							rgb_sel <= 2'd0;
							pix_cnt <= '0;
						end
					end
					PIXELS: begin
						tx_valid <= 1'b1;
						if (rgb_sel == 2'd0)   // prefetch next pixel
							rd_addr <= (pix_cnt == AW'(SEG_PIXELS - 1)) ? '0 : pix_cnt + 1'b1;
						if (rgb_sel == 2'd2) begin
							rgb_sel <= 2'd0;
							if (frame_end) begin
								state <= IDLE;
								segment_num <= segment_num + 1'b1;
								rd_idx <= (rd_idx == SW'(NUM_SEGS - 1)) ? '0 : rd_idx + 1'b1;
							end else begin
								pix_cnt <= pix_cnt + 1'b1;
							end
						end else begin
							rgb_sel <= rgb_sel + 2'd1;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// output byte and held pixel
	always_ff @(posedge clk125MHz) begin
		if (advance) begin
			case (state)
				IDLE: tx_data <= txid;
				HEADER: begin
					case (hdr_cnt)
						2'd1: tx_data <= aux;
						2'd2: tx_data <= segment_num[15:8];
						default: tx_data <= segment_num[7:0];
					endcase
				end
				default: begin
					case (rgb_sel)
						2'd0: begin
							tx_data <= cur_pixel[23:16];
							pix_q <= cur_pixel;   // green and blue come later
						end
						2'd1: tx_data <= pix_q[15:8];
						default: tx_data <= pix_q[7:0];
					endcase
				end
			endcase
		end
	end

endmodule

/* design/ctrl_regs.sv */
`timescale 1ns/100ps

module ctrl_regs (
	input logic clk125MHz,
	input logic reset,
	input vtx_pkg::axil_addr_t s_axil_awaddr,
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input vtx_pkg::axil_data_t s_axil_wdata,
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input logic s_axil_bready,
	input vtx_pkg::axil_addr_t s_axil_araddr,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output vtx_pkg::axil_data_t s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	input logic frame_done,
	input logic pixel_drop,
	output logic enable,
	output vtx_pkg::speed_t speed,
	output vtx_pkg::byte_t txid,
	output vtx_pkg::byte_t aux
);
	import vtx_pkg::*;

	count_t frames_sent;
	count_t pixels_dropped;
	logic wr_go;
	logic wr_hs;
	logic rd_hs;
	axil_data_t rd_word;
	logic rd_err;

	// accept address and data together, one transaction in flight
	assign wr_go = s_axil_awvalid && s_axil_wvalid && !s_axil_awready && !s_axil_bvalid;
	assign wr_hs = s_axil_awvalid && s_axil_awready;
	assign rd_hs = s_axil_arvalid && s_axil_arready;

	// read mux
	always_comb begin
		rd_word = '0;
		rd_err = 1'b0;
		case (s_axil_araddr)
			REG_CTRL: rd_word = {29'd0, speed, enable};
			REG_IDS: rd_word = {16'd0, aux, txid};
			REG_SENT: rd_word = frames_sent;
			REG_DROP: rd_word = pixels_dropped;
			default: rd_err = 1'b1;   // unmapped reads as zero
		endcase
	end

	// ============================================================
	// write channel and control registers
	// ============================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			s_axil_awready <= 1'b0;
			s_axil_wready <= 1'b0;
			s_axil_bvalid <= 1'b0;
			s_axil_bresp <= AXIL_OKAY;
			enable <= 1'b0;
			speed <= SPEED_STOP;
			txid <= '0;
			aux <= '0;
		end else begin
			s_axil_awready <= wr_go;
			s_axil_wready <= wr_go;
			if (wr_hs) begin
				s_axil_bvalid <= 1'b1;
				s_axil_bresp <= AXIL_OKAY;
				case (s_axil_awaddr)
					REG_CTRL: begin
						enable <= s_axil_wdata[0];
						speed <= s_axil_wdata[2:1];
					end
					REG_IDS: begin
						txid <= s_axil_wdata[7:0];
						aux <= s_axil_wdata[15:8];
					end
					REG_SENT, REG_DROP: ;   // read only, write ignored
					default: s_axil_bresp <= AXIL_SLVERR;
				endcase
			end else if (s_axil_bready) begin
				s_axil_bvalid <= 1'b0;
			end
		end
	end

	// ============================================================
	// read channel
	// ============================================================
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			s_axil_arready <= 1'b0;
			s_axil_rvalid <= 1'b0;
			s_axil_rresp <= AXIL_OKAY;
		end else begin
			s_axil_arready <= s_axil_arvalid && !s_axil_arready && !s_axil_rvalid;
			if (rd_hs) begin
				s_axil_rvalid <= 1'b1;
				s_axil_rresp <= rd_err ? AXIL_SLVERR : AXIL_OKAY;
			end else if (s_axil_rready) begin
				s_axil_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (rd_hs)
			s_axil_rdata <= rd_word;
	end

	// status counters, both wrap
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			frames_sent <= '0;
			pixels_dropped <= '0;
		end else begin
			if (frame_done)
				frames_sent <= frames_sent + 1'b1;
			if (pixel_drop)
				pixels_dropped <= pixels_dropped + 1'b1;
		end
	end

endmodule

/* design/video_eth_tx.sv */
`timescale 1ns/100ps

module video_eth_tx #(
	parameter int SEG_PIXELS = 16,
	parameter int NUM_SEGS = 4
) (
	input logic clk125MHz,
	input logic reset,
	// pixel input
	input vtx_pkg::pixel_t pixel,
	input logic pixel_valid,
	// register access
	input vtx_pkg::axil_addr_t s_axil_awaddr,
	input logic s_axil_awvalid,
	output logic s_axil_awready,
	input vtx_pkg::axil_data_t s_axil_wdata,
	input logic s_axil_wvalid,
	output logic s_axil_wready,
	output logic [1:0] s_axil_bresp,
	output logic s_axil_bvalid,
	input logic s_axil_bready,
	input vtx_pkg::axil_addr_t s_axil_araddr,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output vtx_pkg::axil_data_t s_axil_rdata,
	output logic [1:0] s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,
	// byte stream
	output vtx_pkg::byte_t tx_data,
	output logic tx_valid,
	output logic tx_last
);
	import vtx_pkg::*;

	logic enable;
	speed_t speed;
	byte_t txid;
	byte_t aux;
	logic frame_done;
	logic pixel_drop;

	seg_bus_if #(.SEG_PIXELS(SEG_PIXELS)) segs [NUM_SEGS] ();

	// ============================================================
	// control and status
	// ============================================================
	ctrl_regs ctrl_regs_inst (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.frame_done(frame_done),
		.pixel_drop(pixel_drop),
		.enable(enable),
		.speed(speed),
		.txid(txid),
		.aux(aux)
	);

	// ============================================================
	// segment ring
	// ============================================================
	pixel_distributor #(.SEG_PIXELS(SEG_PIXELS), .NUM_SEGS(NUM_SEGS)) pixel_distributor_inst (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.segs(segs),
		.pixel_drop(pixel_drop)
	);

	for (genvar i = 0; i < NUM_SEGS; i++) begin : g_buf
		segment_buffer #(.SEG_PIXELS(SEG_PIXELS)) segment_buffer_inst (
			.clk125MHz(clk125MHz),
			.reset(reset),
			.seg(segs[i])
		);
	end

	frame_builder #(.SEG_PIXELS(SEG_PIXELS), .NUM_SEGS(NUM_SEGS)) frame_builder_inst (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.enable(enable),
		.speed(speed),
		.txid(txid),
		.aux(aux),
		.segs(segs),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last),
		.frame_done(frame_done)
	);

endmodule

/* verif/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ============================================================
// failure handling and compares
// ============================================================
task automatic stop_run();
	$display("SIMULATION FAILED");
	$fatal(1, "stopped at the first error");
endtask

task automatic check_byte(input byte_t got, input byte_t want, input string what);
	if (got !== want) begin
		$display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, want);
		stop_run();
	end
endtask

task automatic check_reg(input axil_data_t got, input axil_data_t want, input string what);
	if (got !== want) begin
		$display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, want);
		stop_run();
	end
endtask

task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string what);
	if (got !== want) begin
		$display("mismatch at time %0t: %s, got %b expected %b", $time, what, got, want);
		stop_run();
	end
endtask

task automatic check_flag(input logic got, input logic want, input string what);
	if (got !== want) begin
		$display("mismatch at time %0t: %s, got %b expected %b", $time, what, got, want);
		stop_run();
	end
endtask

task automatic check_gap(input int got, input int want, input string what);
	if (got != want) begin
		$display("mismatch at time %0t: %s, got %0d expected %0d", $time, what, got, want);
		stop_run();
	end
endtask

// ============================================================
// register access
// ============================================================
task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
	output logic [1:0] resp);
	@(negedge clk125MHz);
	s_axil_awaddr = addr;
	s_axil_wdata = data;
	s_axil_awvalid = 1'b1;
	s_axil_wvalid = 1'b1;
	do @(negedge clk125MHz); while (!s_axil_awready);
	check_flag(s_axil_wready, 1'b1, "wready with awready");
	@(negedge clk125MHz);   // handshake done at the last rising edge
	s_axil_awvalid = 1'b0;
	s_axil_wvalid = 1'b0;
	while (!s_axil_bvalid)
		@(negedge clk125MHz);
	resp = s_axil_bresp;
	s_axil_bready = 1'b1;
	@(negedge clk125MHz);
	s_axil_bready = 1'b0;
endtask

task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
	output logic [1:0] resp);
	@(negedge clk125MHz);
	s_axil_araddr = addr;
	s_axil_arvalid = 1'b1;
	do @(negedge clk125MHz); while (!s_axil_arready);
	@(negedge clk125MHz);
	s_axil_arvalid = 1'b0;
	while (!s_axil_rvalid)
		@(negedge clk125MHz);
	data = s_axil_rdata;
	resp = s_axil_rresp;
	s_axil_rready = 1'b1;
	@(negedge clk125MHz);
	s_axil_rready = 1'b0;
endtask

task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
	logic [1:0] resp;
	axil_write(addr, data, resp);
	check_resp(resp, AXIL_OKAY, "write response");
endtask

task automatic expect_reg(input axil_addr_t addr, input axil_data_t want, input string what);
	logic [1:0] resp;
	axil_data_t data;
	axil_read(addr, data, resp);
	check_resp(resp, AXIL_OKAY, "read response");
	check_reg(data, want, what);
endtask

// ============================================================
// pixels in, bytes out
// ============================================================
// only the first keep pixels are expected to land in a buffer
task automatic send_pixels(input int count, input int keep);
	pixel_t p;
	for (int i = 0; i < count; i++) begin
		@(negedge clk125MHz);
		p = pixel_t'($random(seed));
		pixel = p;
		pixel_valid = 1'b1;
		if (i < keep)
			sent_pix.push_back(p);
	end
	@(negedge clk125MHz);
	pixel_valid = 1'b0;
endtask

// spacing of the first count bytes without consuming them
task automatic check_pacing(input int count, input int gap);
	while (rx_data.size() < count)
		@(negedge clk125MHz);
	for (int i = 1; i < count; i++)
		check_gap(rx_cycle[i] - rx_cycle[i - 1], gap, "cycles between bytes");
endtask

task automatic receive_frame(input byte_t id, input byte_t ax);
	byte_t want[$];
	pixel_t p;
	want.push_back(id);
	want.push_back(ax);
	want.push_back(seg_model[15:8]);
	want.push_back(seg_model[7:0]);
	for (int k = 0; k < SEG_PIXELS; k++) begin
		p = sent_pix.pop_front();
		want.push_back(p[23:16]);   // red first
		want.push_back(p[15:8]);
		want.push_back(p[7:0]);
	end
	while (rx_data.size() < FRAME_BYTES)
		@(negedge clk125MHz);
	for (int i = 0; i < FRAME_BYTES; i++) begin
		check_byte(rx_data.pop_front(), want[i],
			$sformatf("segment %0d byte %0d", seg_model, i));
		check_flag(rx_last.pop_front(), logic'(i == FRAME_BYTES - 1), "tx_last");
		void'(rx_cycle.pop_front());
	end
	seg_model = seg_model + 1'b1;
	frames_seen++;
endtask

`endif

/* verif/tb_video_eth_tx.sv */
`timescale 1ns/100ps

module tb_video_eth_tx;
	import vtx_pkg::*;

	localparam int SEG_PIXELS = 16;
	localparam int NUM_SEGS = 4;
	localparam int FRAME_BYTES = HDR_BYTES + 3 * SEG_PIXELS;

	// ============================================================
	// run time limit, worst case per test in cycles
	// ============================================================
	localparam int AXI_CYCLES = 16;    // one register access with margin
	localparam int T_REGS = 14 * AXI_CYCLES;
	localparam int T_SINGLE = 3 * AXI_CYCLES + SEG_PIXELS + FRAME_BYTES;
	localparam int T_SEQ = 4 * (AXI_CYCLES + SEG_PIXELS + FRAME_BYTES);
	localparam int T_PACE = 4 * AXI_CYCLES + 2 * SEG_PIXELS + 10 * (FRAME_BYTES + 1) +
		100 * 3 + 2 * FRAME_BYTES;
	localparam int T_OVF = 7 * AXI_CYCLES + 5 * SEG_PIXELS + 6 * FRAME_BYTES;
	localparam int LIMIT_CYCLES = 2 * (10 + T_REGS + T_SINGLE + T_SEQ + T_PACE + T_OVF);

	logic clk125MHz = 1'b0;
	logic reset;
	pixel_t pixel;
	logic pixel_valid;
	axil_addr_t s_axil_awaddr;
	logic s_axil_awvalid;
	logic s_axil_awready;
	axil_data_t s_axil_wdata;
	logic s_axil_wvalid;
	logic s_axil_wready;
	logic [1:0] s_axil_bresp;
	logic s_axil_bvalid;
	logic s_axil_bready;
	axil_addr_t s_axil_araddr;
	logic s_axil_arvalid;
	logic s_axil_arready;
	axil_data_t s_axil_rdata;
	logic [1:0] s_axil_rresp;
	logic s_axil_rvalid;
	logic s_axil_rready;
	byte_t tx_data;
	logic tx_valid;
	logic tx_last;

	integer seed = 78135;
	int cycle = 0;
	int frames_seen = 0;
	seg_num_t seg_model = '0;   // next expected segment number
	pixel_t sent_pix[$];        // accepted pixels, oldest first
	byte_t rx_data[$];
	logic rx_last[$];
	int rx_cycle[$];

	`include "tb_tasks.svh"

	video_eth_tx #(.SEG_PIXELS(SEG_PIXELS), .NUM_SEGS(NUM_SEGS)) video_eth_tx_inst (
		.clk125MHz(clk125MHz),
		.reset(reset),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.s_axil_awaddr(s_axil_awaddr),
		.s_axil_awvalid(s_axil_awvalid),
		.s_axil_awready(s_axil_awready),
		.s_axil_wdata(s_axil_wdata),
		.s_axil_wvalid(s_axil_wvalid),
		.s_axil_wready(s_axil_wready),
		.s_axil_bresp(s_axil_bresp),
		.s_axil_bvalid(s_axil_bvalid),
		.s_axil_bready(s_axil_bready),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_last(tx_last)
	);

	always #4 clk125MHz = ~clk125MHz;   // 125 MHz

	always @(posedge clk125MHz) cycle <= cycle + 1;

	// byte monitor, outputs are settled at the falling edge
	always @(negedge clk125MHz) begin
		if (!reset && tx_valid) begin
			rx_data.push_back(tx_data);
			rx_last.push_back(tx_last);
			rx_cycle.push_back(cycle);
		end
	end

	// ============================================================
	// directed tests
	// ============================================================
	task automatic registers_rw();
		logic [1:0] resp;
		axil_data_t data;
		check_flag(tx_valid, 1'b0, "tx_valid after reset");
		check_flag(s_axil_bvalid, 1'b0, "bvalid after reset");
		check_flag(s_axil_rvalid, 1'b0, "rvalid after reset");
		expect_reg(REG_CTRL, '0, "ctrl after reset");
		expect_reg(REG_SENT, '0, "frames sent after reset");
		expect_reg(REG_DROP, '0, "drops after reset");
		write_reg(REG_CTRL, 32'h0000_0006);   // 1000 Mb/s, disabled
		write_reg(REG_IDS, 32'hFFFF_5A3C);    // upper half not stored
		expect_reg(REG_CTRL, 32'h0000_0006, "ctrl readback");
		expect_reg(REG_IDS, 32'h0000_5A3C, "ids readback");
		write_reg(REG_SENT, 32'h1234_5678);   // read only, answered okay
		expect_reg(REG_SENT, '0, "frames sent after write");
		// offsets off the register grid
		axil_write(4'h6, 32'h0000_00FF, resp);
		check_resp(resp, AXIL_SLVERR, "unmapped write response");
		axil_read(4'h2, data, resp);
		check_resp(resp, AXIL_SLVERR, "unmapped read response");
		check_reg(data, '0, "unmapped read data");
		expect_reg(REG_IDS, 32'h0000_5A3C, "ids after unmapped write");
	endtask

	task automatic single_frame();
		write_reg(REG_IDS, 32'h0000_A1C3);
		write_reg(REG_CTRL, 32'h0000_0007);   // enabled at 1000 Mb/s
		send_pixels(SEG_PIXELS, SEG_PIXELS);
		check_pacing(FRAME_BYTES, 1);
		receive_frame(8'hC3, 8'hA1);
	endtask

	task automatic frame_sequence();
		byte_t id;
		for (int k = 0; k < 4; k++) begin
			id = byte_t'(32'h20 + k);
			write_reg(REG_IDS, {16'h0000, 8'h77, id});
			send_pixels(SEG_PIXELS, SEG_PIXELS);
			receive_frame(id, 8'h77);
		end
	endtask

	task automatic byte_pacing();
		write_reg(REG_IDS, 32'h0000_0B0A);
		write_reg(REG_CTRL, 32'h0000_0005);   // 100 Mb/s
		send_pixels(SEG_PIXELS, SEG_PIXELS);
		check_pacing(FRAME_BYTES, 10);
		receive_frame(8'h0A, 8'h0B);
		write_reg(REG_CTRL, 32'h0000_0003);   // 10 Mb/s
		send_pixels(SEG_PIXELS, SEG_PIXELS);
		check_pacing(3, 100);
		write_reg(REG_CTRL, 32'h0000_0007);   // rest of the frame at full rate
		receive_frame(8'h0A, 8'h0B);
	endtask

	task automatic overflow_drop();
		logic [1:0] resp;
		axil_data_t drops0;
		axil_data_t sent0;
		int seen0;
		axil_read(REG_DROP, drops0, resp);
		check_resp(resp, AXIL_OKAY, "drop read response");
		axil_read(REG_SENT, sent0, resp);
		check_resp(resp, AXIL_OKAY, "sent read response");
		seen0 = frames_seen;
		write_reg(REG_CTRL, 32'h0000_0006);   // builder held off
		send_pixels(5 * SEG_PIXELS, NUM_SEGS * SEG_PIXELS);
		expect_reg(REG_DROP, drops0 + 32'(SEG_PIXELS), "dropped pixels");
		write_reg(REG_CTRL, 32'h0000_0007);
		repeat (NUM_SEGS) receive_frame(8'h0A, 8'h0B);
		repeat (2 * FRAME_BYTES) @(negedge clk125MHz);
		check_reg(axil_data_t'(rx_data.size()), '0, "bytes after the last frame");
		expect_reg(REG_SENT, sent0 + axil_data_t'(frames_seen - seen0), "frames sent");
	endtask

	// watchdog
	initial begin
		#(LIMIT_CYCLES * 8);
		$display("error: no result after %0d cycles, the DUT stalled", LIMIT_CYCLES);
		stop_run();
	end

	initial begin
		reset = 1'b1;
		pixel = '0;
		pixel_valid = 1'b0;
		s_axil_awaddr = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata = '0;
		s_axil_wvalid = 1'b0;
		s_axil_bready = 1'b0;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		repeat (3) @(posedge clk125MHz);
		@(negedge clk125MHz);
		reset = 1'b0;
		registers_rw();
		single_frame();
		frame_sequence();
		byte_pacing();
		overflow_drop();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+verif
design/vtx_pkg.sv
design/seg_bus_if.sv
design/segment_buffer.sv
design/pixel_distributor.sv
design/frame_builder.sv
design/ctrl_regs.sv
design/video_eth_tx.sv
verif/tb_video_eth_tx.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps -f flist.f \
	--top-module tb_video_eth_tx; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_video_eth_tx 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
